/* common/lsPkg.sv */
package lsPkg;

	// Datapath sizes
	localparam int dataWidth = 16;
	localparam int regCount = 16;

	// Special registers used as base in the offset modes
	localparam int regFp = 13;
	localparam int regSp = 14;
	localparam int regRs = 15;

	// Instruction field positions
	localparam int groupHi = 15;
	localparam int groupLo = 14;
	localparam int incfHi = 13;
	localparam int incfLo = 12;
	localparam int ldsfHi = 11;
	localparam int ldsfLo = 10;
	localparam int modeHi = 9;
	localparam int modeLo = 8;
	localparam int raHi = 7;
	localparam int raLo = 4;
	localparam int rbHi = 3;
	localparam int rbLo = 0;

	typedef enum logic [1:0] {
		FETCH   = 2'd0,
		DECODE  = 2'd1,
		EXECUTE = 2'd2,
		COMMIT  = 2'd3
	} phase_t;

	typedef enum logic [1:0] {
		GROUP_GENERAL    = 2'd0,
		GROUP_LOAD_STORE = 2'd1,
		GROUP_JUMP       = 2'd2,
		GROUP_ALU        = 2'd3
	} group_t;

	// INC_OFFSET is never encoded in the register-memory form
	typedef enum logic [1:0] {
		INC_NONE     = 2'd0,
		INC_PRE_DEC  = 2'd1,
		INC_POST_INC = 2'd2,
		INC_OFFSET   = 2'd3
	} incMode_t;

	typedef enum logic [1:0] {
		LD  = 2'd0,
		ST  = 2'd1,
		LDB = 2'd2,
		STB = 2'd3
	} ldsOp_t;

	typedef enum logic [1:0] {
		MODE_REG_MEM = 2'd0,
		MODE_FP      = 2'd1,
		MODE_SP      = 2'd2,
		MODE_RS      = 2'd3
	} lsMode_t;

	typedef enum logic [1:0] {
		SRC_ZERO      = 2'd0,
		SRC_TWO       = 2'd1,
		SRC_MINUS_TWO = 2'd2,
		SRC_S6        = 2'd3
	} aluASrc_t;

	typedef enum logic {
		ADDR_REG_B = 1'b0,
		ADDR_ALU   = 1'b1
	} addrSel_t;

	typedef enum logic [1:0] {
		RB_ARG = 2'd0,
		RB_FP  = 2'd1,
		RB_SP  = 2'd2,
		RB_RS  = 2'd3
	} regBSel_t;

endpackage

/* hdl/phaseSequencer.sv */
`timescale 1ns/1ps

module phaseSequencer import lsPkg::*; (
	input  logic                 CLK,
	input  logic                 rstN,
	input  logic                 instrValid,
	input  logic [dataWidth-1:0] instr,
	output phase_t               phase,
	output logic [dataWidth-1:0] latchedInstr,
	output logic                 fetchReady
);

	// Set for the one FETCH cycle that follows the accepting edge
	logic fetched;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			phase <= FETCH;
			fetched <= 1'b0;
			latchedInstr <= '0;
		end else begin
			case (phase)
				FETCH: begin
					if (fetched) begin
						phase <= DECODE;
						fetched <= 1'b0;
					end else if (instrValid) begin
						latchedInstr <= instr;
						fetched <= 1'b1;
					end
				end
				DECODE: begin
					phase <= EXECUTE;
				end
				EXECUTE: begin
					phase <= COMMIT;
				end
				COMMIT: begin
					phase <= FETCH;
				end
				default: begin
					phase <= FETCH;
				end
			endcase
		end
	end

	// Strobes are only taken while idle in FETCH
	assign fetchReady = (phase == FETCH) && !fetched;

endmodule

/* decoder/loadStoreGroupDecoder.sv */
`timescale 1ns/1ps

module loadStoreGroupDecoder import lsPkg::*; (
	input  phase_t               phase,
	input  logic [dataWidth-1:0] instr,
	// Register file
	output logic                 regAEn,
	output logic                 regBEn,
	output logic                 regAWen,
	output logic                 regBWen,
	output logic [3:0]           regAAddr,
	output logic [3:0]           regBAddr,
	// Address unit
	output aluASrc_t             aluASrc,
	output addrSel_t             addrSel,
	output logic [5:0]           offset,
	// Bus unit
	output logic                 busRd,
	output logic                 busWr,
	output logic                 isByte
);

	group_t   group;
	incMode_t incField;
	incMode_t incMode;
	ldsOp_t   ldsOp;
	lsMode_t  lsMode;
	regBSel_t regBSel;
	logic     isLoadStore;
	logic     inExecute;
	logic     inCommit;
	logic     isLoad;

	// Instruction fields
	assign group = group_t'(instr[groupHi:groupLo]);
	assign incField = incMode_t'(instr[incfHi:incfLo]);
	assign ldsOp = ldsOp_t'(instr[ldsfHi:ldsfLo]);
	assign lsMode = lsMode_t'(instr[modeHi:modeLo]);

	assign isLoadStore = (group == GROUP_LOAD_STORE);
	assign inExecute = isLoadStore && (phase == EXECUTE);
	assign inCommit = isLoadStore && (phase == COMMIT);

	assign isLoad = (ldsOp == LD) || (ldsOp == LDB);

	// Signed offset, incf on top of the Rb field
	assign offset = {instr[incfHi:incfLo], instr[rbHi:rbLo]};

	// Offset modes reuse incf as offset bits
	always_comb begin
		if (lsMode != MODE_REG_MEM) begin
			incMode = INC_OFFSET;
		end else if (incField == INC_OFFSET) begin
			// Reserved encoding, plain access
			incMode = INC_NONE;
		end else begin
			incMode = incField;
		end
	end

	always_comb begin
		case (lsMode)
			MODE_FP: regBSel = RB_FP;
			MODE_SP: regBSel = RB_SP;
			MODE_RS: regBSel = RB_RS;
			default: regBSel = RB_ARG;
		endcase
	end

	// Base register number
	always_comb begin
		case (regBSel)
			RB_FP:   regBAddr = 4'(regFp);
			RB_SP:   regBAddr = 4'(regSp);
			RB_RS:   regBAddr = 4'(regRs);
			default: regBAddr = instr[rbHi:rbLo];
		endcase
	end

	assign regAAddr = instr[raHi:raLo];

	// Adder operand and address source
	always_comb begin
		case (incMode)
			INC_PRE_DEC: begin
				aluASrc = SRC_MINUS_TWO;
				addrSel = ADDR_ALU;
			end
			INC_POST_INC: begin
				aluASrc = SRC_TWO;
				addrSel = ADDR_REG_B;
			end
			INC_OFFSET: begin
				aluASrc = SRC_S6;
				addrSel = ADDR_ALU;
			end
			default: begin
				aluASrc = SRC_ZERO;
				addrSel = ADDR_REG_B;
			end
		endcase
	end

	assign regAEn = inExecute || inCommit;
	assign regBEn = inExecute || inCommit;

	// One bus cycle in EXECUTE
	assign busRd = inExecute && isLoad;
	assign busWr = inExecute && !isLoad;
	assign isByte = isLoadStore && ((ldsOp == LDB) || (ldsOp == STB));

	// Writes land at the end of COMMIT
	assign regAWen = inCommit && isLoad;
	assign regBWen = inCommit && ((incMode == INC_PRE_DEC) || (incMode == INC_POST_INC));

endmodule

/* hdl/registerFile.sv */
`timescale 1ns/1ps

module registerFile import lsPkg::*; (
	input  logic                 CLK,
	input  logic                 rstN,
	input  logic [3:0]           aAddr,
	input  logic [3:0]           bAddr,
	input  logic                 aWen,
	input  logic                 bWen,
	input  logic [dataWidth-1:0] aWrData,
	input  logic [dataWidth-1:0] bWrData,
	output logic [dataWidth-1:0] aRdData,
	output logic [dataWidth-1:0] bRdData
);

	logic [dataWidth-1:0] regs [regCount];

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// Port B first so port A takes a shared address
			if (bWen) begin
				regs[bAddr] <= bWrData;
			end
			if (aWen) begin
				regs[aAddr] <= aWrData;
			end
		end
	end

	// Asynchronous reads
	assign aRdData = regs[aAddr];
	assign bRdData = regs[bAddr];

endmodule

/* hdl/addressUnit.sv */
`timescale 1ns/1ps

module addressUnit import lsPkg::*; (
	input  logic                 CLK,
	input  logic                 rstN,
	input  aluASrc_t             aluASrc,
	input  addrSel_t             addrSel,
	input  logic [5:0]           offset,
	input  logic [dataWidth-1:0] regB,
	output logic [dataWidth-1:0] addr,
	output logic [dataWidth-1:0] updateValue
);

	logic [dataWidth-1:0] operandA;
	logic [dataWidth-1:0] sum;

	// Increment or sign-extended offset
	always_comb begin
		case (aluASrc)
			SRC_TWO: begin
				operandA = dataWidth'(2);
			end
			SRC_MINUS_TWO: begin
				operandA = {{(dataWidth - 2){1'b1}}, 2'b10};
			end
			SRC_S6: begin
				operandA = {{(dataWidth - 6){offset[5]}}, offset};
			end
			default: begin
				operandA = '0;
			end
		endcase
	end

	assign sum = regB + operandA;

	// Post-increment addresses with the old base
	assign addr = (addrSel == ADDR_ALU) ? sum : regB;

	// Inputs hold steady through COMMIT, so the value sampled
	// at the end of EXECUTE is what the base write sees
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			updateValue <= '0;
		end else begin
			updateValue <= sum;
		end
	end

endmodule

/* hdl/memBusUnit.sv */
`timescale 1ns/1ps

module memBusUnit import lsPkg::*; (
	input  logic                 CLK,
	input  logic                 rstN,
	input  logic                 busRd,
	input  logic                 busWr,
	input  logic                 isByte,
	input  logic [dataWidth-1:0] addr,
	input  logic [dataWidth-1:0] storeData,
	input  logic [dataWidth-1:0] memRdData,
	output logic [dataWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWrData,
	output logic [1:0]           memByteEn,
	output logic                 memRd,
	output logic                 memWr,
	output logic [dataWidth-1:0] loadData
);

	// High lane chosen by the read in EXECUTE
	logic laneHi;
	logic [7:0] loadByte;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			laneHi <= 1'b0;
		end else if (busRd) begin
			laneHi <= addr[0];
		end
	end

	assign memAddr = addr;
	assign memRd = busRd;
	assign memWr = busWr;

	// Lanes only enabled during a bus cycle
	always_comb begin
		if (!(busRd || busWr)) begin
			memByteEn = 2'b00;
		end else if (!isByte) begin
			memByteEn = 2'b11;
		end else begin
			memByteEn = addr[0] ? 2'b10 : 2'b01;
		end
	end

	// Byte stores drive the low byte on both lanes
	assign memWrData = isByte ? {storeData[7:0], storeData[7:0]} : storeData;

	assign loadByte = laneHi ? memRdData[15:8] : memRdData[7:0];
	assign loadData = isByte ? {8'h00, loadByte} : memRdData;

endmodule

/* hdl/loadStoreCore.sv */
`timescale 1ns/1ps

module loadStoreCore import lsPkg::*; (
	input  logic                 CLK,
	input  logic                 rstN,
	input  logic                 instrValid,
	input  logic [dataWidth-1:0] instr,
	output logic                 fetchReady,
	output logic [dataWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWrData,
	output logic [1:0]           memByteEn,
	output logic                 memRd,
	output logic                 memWr,
	input  logic [dataWidth-1:0] memRdData
);

	phase_t               phase;
	logic [dataWidth-1:0] latchedInstr;

	// Decoder controls
	logic                 regAWen;
	logic                 regBWen;
	logic [3:0]           regAAddr;
	logic [3:0]           regBAddr;
	aluASrc_t             aluASrc;
	addrSel_t             addrSel;
	logic [5:0]           offset;
	logic                 busRd;
	logic                 busWr;
	logic                 isByte;

	// Datapath
	logic [dataWidth-1:0] regAData;
	logic [dataWidth-1:0] regBData;
	logic [dataWidth-1:0] addr;
	logic [dataWidth-1:0] updateValue;
	logic [dataWidth-1:0] loadData;

	phaseSequencer phaseSequencer_i (
		.CLK(CLK), .rstN(rstN), .instrValid(instrValid), .instr(instr),
		.phase(phase), .latchedInstr(latchedInstr), .fetchReady(fetchReady)
	);

	loadStoreGroupDecoder loadStoreGroupDecoder_i (
		.phase(phase), .instr(latchedInstr),
		.regAEn(), .regBEn(), .regAWen(regAWen), .regBWen(regBWen),
		.regAAddr(regAAddr), .regBAddr(regBAddr),
		.aluASrc(aluASrc), .addrSel(addrSel), .offset(offset),
		.busRd(busRd), .busWr(busWr), .isByte(isByte)
	);

	registerFile registerFile_i (
		.CLK(CLK), .rstN(rstN), .aAddr(regAAddr), .bAddr(regBAddr),
		.aWen(regAWen), .bWen(regBWen), .aWrData(loadData), .bWrData(updateValue),
		.aRdData(regAData), .bRdData(regBData)
	);

	addressUnit addressUnit_i (
		.CLK(CLK), .rstN(rstN), .aluASrc(aluASrc), .addrSel(addrSel),
		.offset(offset), .regB(regBData), .addr(addr), .updateValue(updateValue)
	);

	// Store data comes straight from Ra
	memBusUnit memBusUnit_i (
		.CLK(CLK), .rstN(rstN), .busRd(busRd), .busWr(busWr), .isByte(isByte),
		.addr(addr), .storeData(regAData), .memRdData(memRdData),
		.memAddr(memAddr), .memWrData(memWrData), .memByteEn(memByteEn),
		.memRd(memRd), .memWr(memWr), .loadData(loadData)
	);

endmodule

/* tb/loadStoreCoreTb.sv */
`timescale 1ns/1ps

module loadStoreCoreTb import lsPkg::*; ();

	localparam int clkPeriod = 8;
	localparam int resetCycles = 10;
	localparam int readyLimit = 20;
	localparam int cyclesPerInstr = 40;
	localparam int marginCycles = 100;
	localparam int kindNone = 0;
	localparam int kindRead = 1;
	localparam int kindWrite = 2;

	logic        CLK;
	logic        rstN;
	logic        instrValid;
	logic [15:0] instr;
	logic [15:0] memRdData;
	logic        fetchReady;
	logic [15:0] memAddr;
	logic [15:0] memWrData;
	logic [1:0]  memByteEn;
	logic        memRd;
	logic        memWr;

	logic [15:0] mem [256];
	logic [15:0] expRegs [16];
	logic [15:0] lfsr;
	int          issued = 0;
	int          cycleCount = 0;

	// Last bus cycle seen by runInstr
	int          busCount;
	logic [15:0] seenAddr;
	logic [15:0] seenWrData;
	logic [1:0]  seenByteEn;
	logic        seenWrite;

	loadStoreCore loadStoreCore_i (
		.CLK(CLK), .rstN(rstN), .instrValid(instrValid), .instr(instr),
		.fetchReady(fetchReady), .memAddr(memAddr), .memWrData(memWrData),
		.memByteEn(memByteEn), .memRd(memRd), .memWr(memWr), .memRdData(memRdData)
	);

	always #(clkPeriod / 2) CLK = ~CLK;

	// Memory model, 256 words, byte addressed
	always @(posedge CLK) begin
		if (memRd) begin
			memRdData <= mem[memAddr[8:1]];
		end
		if (memWr && memByteEn[0]) begin
			mem[memAddr[8:1]][7:0] <= memWrData[7:0];
		end
		if (memWr && memByteEn[1]) begin
			mem[memAddr[8:1]][15:8] <= memWrData[15:8];
		end
	end

	function automatic logic [15:0] stepLfsr(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	task automatic fillMemory();
		logic [15:0] word;
		for (int a = 0; a < 256; a++) begin
			word = '0;
			for (int b = 0; b < 16; b++) begin
				lfsr = stepLfsr(lfsr);
				word = {word[14:0], lfsr[0]};
			end
			mem[a] = word;
		end
	endtask

	task automatic stopOnError();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
			stopOnError();
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		assert (cond) else begin
			$display("Error at time %0t: %s", $time, what);
			stopOnError();
		end
	endtask

	// Backdoor preset of one memory word
	task automatic setWord(input logic [15:0] byteAddr, input logic [15:0] value);
		mem[byteAddr[8:1]] = value;
	endtask

	// Issue one instruction and follow it until fetchReady returns
	task automatic runInstr(input logic [15:0] word, input int expKind);
		int waitCycles;
		int k;
		waitCycles = 0;
		@(negedge CLK);
		while (!fetchReady) begin
			@(negedge CLK);
			waitCycles++;
			checkTrue(waitCycles < readyLimit, "fetchReady stayed low before issue");
		end
		@(posedge CLK);
		instrValid <= 1'b1;
		instr <= word;
		// Acceptance edge
		@(posedge CLK);
		instrValid <= 1'b0;
		issued++;
		busCount = 0;
		seenWrite = 1'b0;
		for (k = 0; k < readyLimit; k++) begin
			@(negedge CLK);
			checkTrue(!(memRd && memWr), "memRd and memWr high together");
			if (memRd || memWr) begin
				busCount++;
				seenAddr = memAddr;
				seenWrData = memWrData;
				seenByteEn = memByteEn;
				seenWrite = memWr;
				checkValue("bus cycle edge", 16'd2, 16'(k));
			end
			if (fetchReady) begin
				break;
			end
		end
		checkTrue(fetchReady, "fetchReady did not return after the instruction");
		checkValue("fetchReady edge", 16'd4, 16'(k));
		checkValue("bus cycle count", (expKind == kindNone) ? 16'd0 : 16'd1, 16'(busCount));
		if (expKind != kindNone) begin
			checkValue("memWr", (expKind == kindWrite) ? 16'd1 : 16'd0, 16'(seenWrite));
		end
	endtask

	// Reference for one load/store, kept in expRegs
	task automatic accessOp(input ldsOp_t op, input lsMode_t mode, input incMode_t inc,
			input logic [3:0] ra, input logic [5:0] arg);
		logic [3:0]  baseIdx;
		logic [1:0]  incf;
		logic [15:0] base;
		logic [15:0] expAddr;
		logic [15:0] newBase;
		logic [15:0] word;
		logic [15:0] loadVal;
		logic [1:0]  expEn;
		logic        byteOp;
		logic        loadOp;
		byteOp = (op == LDB) || (op == STB);
		loadOp = (op == LD) || (op == LDB);
		case (mode)
			MODE_FP: baseIdx = 4'(regFp);
			MODE_SP: baseIdx = 4'(regSp);
			MODE_RS: baseIdx = 4'(regRs);
			default: baseIdx = arg[3:0];
		endcase
		base = expRegs[baseIdx];
		newBase = base;
		if (mode != MODE_REG_MEM) begin
			incf = arg[5:4];
			expAddr = base + {{10{arg[5]}}, arg};
		end else begin
			incf = inc;
			expAddr = (inc == INC_PRE_DEC) ? base - 16'd2 : base;
			if (inc == INC_PRE_DEC) begin
				newBase = base - 16'd2;
			end else if (inc == INC_POST_INC) begin
				newBase = base + 16'd2;
			end
		end
		word = mem[expAddr[8:1]];
		loadVal = word;
		expEn = 2'b11;
		if (byteOp) begin
			loadVal = expAddr[0] ? {8'h00, word[15:8]} : {8'h00, word[7:0]};
			expEn = expAddr[0] ? 2'b10 : 2'b01;
		end
		runInstr({2'b01, incf, op, mode, ra, arg[3:0]}, loadOp ? kindRead : kindWrite);
		checkValue("memAddr", expAddr, seenAddr);
		checkValue("memByteEn", 16'(expEn), 16'(seenByteEn));
		if (!loadOp) begin
			checkValue("memWrData",
				byteOp ? {expRegs[ra][7:0], expRegs[ra][7:0]} : expRegs[ra], seenWrData);
		end
		expRegs[baseIdx] = newBase;
		if (loadOp) begin
			expRegs[ra] = loadVal;
		end
	endtask

	task automatic testResetAndTiming();
		@(negedge CLK);
		checkTrue(fetchReady, "fetchReady low after reset");
		checkTrue(!memRd && !memWr, "bus strobe active after reset");
		accessOp(LD, MODE_REG_MEM, INC_NONE, 4'd1, 6'd0);
	endtask

	task automatic testWordLoadStore();
		accessOp(LD, MODE_REG_MEM, INC_NONE, 4'd2, 6'd0);
		accessOp(ST, MODE_REG_MEM, INC_NONE, 4'd2, 6'd0);
	endtask

	task automatic testIncDec();
		setWord(16'h0000, 16'h0080);
		accessOp(LD, MODE_REG_MEM, INC_NONE, 4'd3, 6'd0);
		accessOp(LD, MODE_REG_MEM, INC_PRE_DEC, 4'd4, 6'd3);
		accessOp(LD, MODE_REG_MEM, INC_PRE_DEC, 4'd4, 6'd3);
		accessOp(LD, MODE_REG_MEM, INC_POST_INC, 4'd5, 6'd3);
		accessOp(LD, MODE_REG_MEM, INC_NONE, 4'd6, 6'd3);
		accessOp(ST, MODE_REG_MEM, INC_NONE, 4'd3, 6'd0);
	endtask

	task automatic testOffsetModes();
		setWord(16'h0000, 16'h0100);
		accessOp(LD, MODE_REG_MEM, INC_NONE, 4'(regFp), 6'd0);
		setWord(16'h0000, 16'h0140);
		accessOp(LD, MODE_REG_MEM, INC_NONE, 4'(regSp), 6'd0);
		setWord(16'h0000, 16'h0180);
		accessOp(LD, MODE_REG_MEM, INC_NONE, 4'(regRs), 6'd0);
		accessOp(LD, MODE_FP, INC_NONE, 4'd7, 6'd6);
		// Offsets of minus 6 and minus 32
		accessOp(LD, MODE_SP, INC_NONE, 4'd8, 6'h3A);
		accessOp(ST, MODE_RS, INC_NONE, 4'd7, 6'h20);
		accessOp(LD, MODE_RS, INC_NONE, 4'd9, 6'h1E);
	endtask

	task automatic testByteAccess();
		setWord(16'h0000, 16'h0051);
		accessOp(LD, MODE_REG_MEM, INC_NONE, 4'd10, 6'd0);
		accessOp(LDB, MODE_REG_MEM, INC_NONE, 4'd11, 6'd10);
		accessOp(ST, MODE_REG_MEM, INC_NONE, 4'd11, 6'd0);
		setWord(16'h0000, 16'h0064);
		accessOp(LD, MODE_REG_MEM, INC_NONE, 4'd12, 6'd0);
		accessOp(STB, MODE_REG_MEM, INC_NONE, 4'd2, 6'd12);
	endtask

	task automatic testOtherGroups();
		// Pre-decrement load shape in group 0, then groups 2 and 3
		runInstr(16'h1013, kindNone);
		runInstr(16'h8030, kindNone);
		runInstr(16'hE413, kindNone);
		accessOp(ST, MODE_REG_MEM, INC_NONE, 4'd1, 6'd0);
		accessOp(ST, MODE_REG_MEM, INC_NONE, 4'd3, 6'd0);
	endtask

	// Limit grows with the instructions issued
	initial begin
		while (cycleCount <= issued * cyclesPerInstr + marginCycles) begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("Timeout after %0d cycles with %0d instructions issued",
			cycleCount, issued);
		stopOnError();
	end

	initial begin
		CLK = 1'b0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		memRdData = '0;
		lfsr = 16'd66;
		for (int i = 0; i < 16; i++) begin
			expRegs[i] = '0;
		end
		fillMemory();
		repeat (resetCycles) @(posedge CLK);
		rstN <= 1'b1;
		testResetAndTiming();
		testWordLoadStore();
		testIncDec();
		testOffsetModes();
		testByteAccess();
		testOtherGroups();
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* all.f */
common/lsPkg.sv
hdl/phaseSequencer.sv
decoder/loadStoreGroupDecoder.sv
hdl/registerFile.sv
hdl/addressUnit.sv
hdl/memBusUnit.sv
hdl/loadStoreCore.sv
tb/loadStoreCoreTb.sv
